// ==== Bender.yml ====
package:
  name: uart_wb

export_include_dirs:
  - hdl

sources:
  - hdl/uart_pkg.sv
  - hdl/uart_wb_decode.sv
  - hdl/uart_baud_detect.sv
  - hdl/uart_rx.sv
  - hdl/uart_tx.sv
  - hdl/uart_wb_result.sv
  - hdl/uart_wb.sv
  - target: test
    files:
      - testbench/uart_wb_tb.sv

// ==== hdl/uart_baud_detect.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_baud_detect (
   input  wire                 clk,
   input  wire                 nRst,
   input  wire                 rx,
   input  wire                 ab_arm,
   input  wire uart_pkg::uart_div_t baud_div,
   output logic                rx_sync,
   output logic                rx_block,
   output logic                ab_load,
   output uart_pkg::uart_div_t ab_div
);
   import uart_pkg::*;

   typedef enum logic [1:0] {AB_IDLE, AB_ARMED, AB_MEASURE, AB_BLANK} ab_state_e;

   ab_state_e  state;
   logic       rx_d1;
   logic       rx_d2;
   uart_div_t  cnt;        // Low cycles, then high cycles in the current period
   logic [3:0] hi_bits;    // Whole idle periods seen after the sync character

   assign rx_sync  = rx_d2;
   assign rx_block = (state != AB_IDLE);   // Receiver ignores the line while armed

   // Line idles high, so the sync flops reset high
   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         rx_d1 <= 1'b1;
         rx_d2 <= 1'b1;
      end else begin
         rx_d1 <= rx;
         rx_d2 <= rx_d1;
      end
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state   <= AB_IDLE;
         cnt     <= '0;
         hi_bits <= 4'd0;
         ab_load <= 1'b0;
         ab_div  <= '0;
      end else begin
         ab_load <= 1'b0;
         case (state)
            AB_IDLE:    if (ab_arm && rx_sync) state <= AB_ARMED;
            AB_ARMED:   begin
                           cnt <= uart_div_t'(1);     // First low cycle
                           if (!ab_arm)
                              state <= AB_IDLE;
                           else if (!rx_sync)
                              state <= AB_MEASURE;
                        end
            AB_MEASURE: begin
                           if (!ab_arm) begin
                              state <= AB_IDLE;
                           end else if (rx_sync) begin   // End of the start bit
                              ab_div  <= cnt;
                              ab_load <= 1'b1;
                              cnt     <= uart_div_t'(1);
                              hi_bits <= 4'd0;
                              state   <= AB_BLANK;
                           end else if (cnt != '1) begin
                              cnt <= cnt + 1'b1;          // Saturates
                           end
                        end
            AB_BLANK:   begin
                           if (!rx_sync) begin
                              cnt     <= '0;
                              hi_bits <= 4'd0;
                           end else if (cnt >= baud_div - 1'b1) begin
                              cnt <= '0;
                              if (hi_bits == 4'd9)
                                 state <= AB_IDLE;    // Ten quiet periods
                              else
                                 hi_bits <= hi_bits + 1'b1;
                           end else begin
                              cnt <= cnt + 1'b1;
                           end
                        end
            default:    state <= AB_IDLE;
         endcase
      end
   end

   a_load_armed: assert property (@(posedge clk) disable iff (!nRst)
      ab_load |-> ab_arm);

endmodule

`default_nettype wire

// ==== hdl/uart_cfg.svh ====
`ifndef UART_CFG_SVH
`define UART_CFG_SVH

// Baud divisor width in bits
`define UART_DIV_W 16

// Clock cycles per bit after reset, kept small for short simulations
`define UART_DEFAULT_DIV 20

// Wishbone word address width
`define UART_ADDR_W 2

`endif

// ==== hdl/uart_pkg.sv ====
`default_nettype none

`include "uart_cfg.svh"

package uart_pkg;

   // Clock cycles per serial bit
   typedef logic [`UART_DIV_W-1:0] uart_div_t;

   // Register map, one byte per word address
   typedef enum logic [1:0] {
      REG_DATA   = 2'd0,
      REG_STATUS = 2'd1,
      REG_BAUD   = 2'd2,
      REG_CTRL   = 2'd3
   } uart_reg_e;

   typedef struct packed {
      logic [3:0] pad;        // Always zero
      logic       ab_armed;
      logic       rx_overrun;
      logic       rx_valid;
      logic       tx_busy;    // Bit 0
   } uart_status_t;

endpackage

`default_nettype wire

// ==== hdl/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
   input  wire                 clk,
   input  wire                 nRst,
   input  wire                 rx_sync,
   input  wire                 rx_block,
   input  wire uart_pkg::uart_div_t baud_div,
   input  wire                 rx_read,
   output logic [7:0]          rx_data,
   output logic                rx_valid,
   output logic                rx_overrun
);
   import uart_pkg::*;

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_WAIT} rx_state_e;

   rx_state_e  state;
   uart_div_t  cnt;
   logic [2:0] bit_idx;
   logic [7:0] shift;
   logic       tick;
   logic       done;
   logic       keep_old;

   assign tick     = (cnt == baud_div - 1'b1);            // Next mid-bit
   assign done     = (state == RX_DATA) && tick && (bit_idx == 3'd7);
   assign keep_old = rx_valid && !rx_read;

   always_ff @(posedge clk) begin
      if (state == RX_DATA && tick)
         shift <= {rx_sync, shift[7:1]};   // LSB arrives first
      if (done && !keep_old)
         rx_data <= {rx_sync, shift[7:1]};
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state      <= RX_IDLE;
         cnt        <= '0;
         bit_idx    <= 3'd0;
         rx_valid   <= 1'b0;
         rx_overrun <= 1'b0;
      end else begin
         cnt <= cnt + 1'b1;
         if (rx_read) begin
            rx_valid   <= 1'b0;
            rx_overrun <= 1'b0;
         end
         case (state)
            RX_IDLE:  begin
                         cnt <= '0;
                         if (!rx_sync && !rx_block)
                            state <= RX_START;
                      end
            RX_START: if (cnt == (baud_div >> 1)) begin   // Half a bit in
                         cnt     <= '0;
                         bit_idx <= 3'd0;
                         state   <= rx_sync ? RX_IDLE : RX_DATA;  // High here is a glitch
                      end
            RX_DATA:  if (tick) begin
                         cnt     <= '0;
                         bit_idx <= bit_idx + 1'b1;
                         if (bit_idx == 3'd7) begin
                            state <= RX_WAIT;
                            if (keep_old) begin
                               rx_overrun <= 1'b1;
                            end else begin
                               rx_valid <= 1'b1;
                            end
                         end
                      end
            RX_WAIT:  if (rx_sync) state <= RX_IDLE;      // Stop bit
            default:  state <= RX_IDLE;
         endcase
         if (rx_block)
            state <= RX_IDLE;                             // Sync character hidden
      end
   end

   a_overrun_valid: assert property (@(posedge clk) disable iff (!nRst)
      rx_overrun |-> rx_valid);

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
   input  wire                 clk,
   input  wire                 nRst,
   input  wire                 tx_start,
   input  wire [7:0]           tx_byte,
   input  wire uart_pkg::uart_div_t baud_div,
   output logic                tx,
   output logic                tx_busy
);
   import uart_pkg::*;

   typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_WAIT, TX_BUSY} tx_state_e;

   tx_state_e  state;
   uart_div_t  cnt;
   uart_div_t  div_q;      // Frame rate, fixed until the frame ends
   logic [2:0] bit_idx;
   logic [7:0] shift;
   logic       tick;
   logic       shift_en;

   assign tick     = (cnt == div_q - 1'b1);
   assign shift_en = tick && (state == TX_START || (state == TX_DATA && bit_idx != 3'd7));

   always_ff @(posedge clk) begin
      if (state == TX_IDLE && tx_start) begin
         shift <= tx_byte;
         div_q <= baud_div;
      end else if (shift_en) begin
         shift <= shift >> 1;
      end
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_idx <= 3'd0;
         tx      <= 1'b1;
         tx_busy <= 1'b0;
      end else begin
         cnt <= tick ? '0 : cnt + 1'b1;
         case (state)
            TX_IDLE:  begin
                         cnt <= '0;
                         if (tx_start) begin
                            tx      <= 1'b0;        // Start bit
                            tx_busy <= 1'b1;
                            state   <= TX_START;
                         end
                      end
            TX_START: if (tick) begin
                         tx      <= shift[0];
                         bit_idx <= 3'd0;
                         state   <= TX_DATA;
                      end
            TX_DATA:  if (tick) begin
                         bit_idx <= bit_idx + 1'b1;
                         if (bit_idx == 3'd7) begin
                            tx    <= 1'b1;          // Stop bit
                            state <= TX_WAIT;
                         end else begin
                            tx <= shift[0];
                         end
                      end
            TX_WAIT:  if (tick) state <= TX_BUSY;   // Then one idle period
            TX_BUSY:  if (tick) begin
                         tx_busy <= 1'b0;
                         state   <= TX_IDLE;
                      end
            default:  state <= TX_IDLE;
         endcase
      end
   end

   a_idle_high: assert property (@(posedge clk) disable iff (!nRst)
      !tx_busy |-> tx);

endmodule

`default_nettype wire

// ==== hdl/uart_wb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uart_wb (
   input  wire                    clk,
   input  wire                    nRst,
   input  wire                    wb_cyc,
   input  wire                    wb_stb,
   input  wire                    wb_we,
   input  wire [`UART_ADDR_W-1:0] wb_adr,
   input  wire [7:0]              wb_dat_i,
   output logic [7:0]             wb_dat_o,
   output logic                   wb_ack,
   input  wire                    rx,
   output logic                   tx
);
   import uart_pkg::*;

   uart_reg_e    adr_e;
   uart_reg_e    rd_sel;
   uart_div_t    baud_div;
   uart_div_t    ab_div;
   uart_status_t status;
   logic         tx_start;
   logic [7:0]   tx_byte;
   logic         tx_busy;
   logic         rx_read;
   logic         ab_arm;
   logic         ab_load;
   logic         rx_sync;
   logic         rx_block;
   logic [7:0]   rx_data;
   logic         rx_valid;
   logic         rx_overrun;

   assign adr_e  = uart_reg_e'(wb_adr);
   assign status = '{pad: 4'd0, ab_armed: ab_arm, rx_overrun: rx_overrun,
                     rx_valid: rx_valid, tx_busy: tx_busy};

   uart_wb_decode decode_i (
      .clk(clk), .nRst(nRst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(adr_e), .wb_dat_i(wb_dat_i), .tx_busy(tx_busy), .ab_load(ab_load),
      .ab_div(ab_div), .tx_start(tx_start), .tx_byte(tx_byte), .rx_read(rx_read),
      .rd_sel(rd_sel), .baud_div(baud_div), .ab_arm(ab_arm));

   uart_baud_detect detect_i (
      .clk(clk), .nRst(nRst), .rx(rx), .ab_arm(ab_arm), .baud_div(baud_div),
      .rx_sync(rx_sync), .rx_block(rx_block), .ab_load(ab_load), .ab_div(ab_div));

   uart_tx tx_i (
      .clk(clk), .nRst(nRst), .tx_start(tx_start), .tx_byte(tx_byte),
      .baud_div(baud_div), .tx(tx), .tx_busy(tx_busy));

   uart_rx rx_i (
      .clk(clk), .nRst(nRst), .rx_sync(rx_sync), .rx_block(rx_block),
      .baud_div(baud_div), .rx_read(rx_read), .rx_data(rx_data),
      .rx_valid(rx_valid), .rx_overrun(rx_overrun));

   uart_wb_result result_i (
      .clk(clk), .nRst(nRst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .rd_sel(rd_sel),
      .rx_data(rx_data), .status(status), .baud_div(baud_div),
      .wb_dat_o(wb_dat_o), .wb_ack(wb_ack));

endmodule

`default_nettype wire

// ==== hdl/uart_wb_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uart_wb_decode (
   input  wire                 clk,
   input  wire                 nRst,
   input  wire                 wb_cyc,
   input  wire                 wb_stb,
   input  wire                 wb_we,
   input  wire uart_pkg::uart_reg_e wb_adr,
   input  wire [7:0]           wb_dat_i,
   input  wire                 tx_busy,
   input  wire                 ab_load,
   input  wire uart_pkg::uart_div_t ab_div,
   output logic                tx_start,
   output logic [7:0]          tx_byte,
   output logic                rx_read,
   output uart_pkg::uart_reg_e rd_sel,
   output uart_pkg::uart_div_t baud_div,
   output logic                ab_arm
);
   import uart_pkg::*;

   logic req_q;         // Tracks the ack cycle of the result block
   logic access;
   logic wr_en;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst)
         req_q <= 1'b0;
      else
         req_q <= wb_cyc & wb_stb & !req_q;   // Never high twice in a row
   end

   assign access   = req_q & wb_cyc & wb_stb;
   assign wr_en    = access & wb_we;
   assign tx_start = wr_en & (wb_adr == REG_DATA) & !tx_busy;  // Busy writes are lost
   assign tx_byte  = wb_dat_i;
   assign rx_read  = access & !wb_we & (wb_adr == REG_DATA);
   assign rd_sel   = wb_adr;

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst) begin
         baud_div <= uart_div_t'(`UART_DEFAULT_DIV);
         ab_arm   <= 1'b0;
      end else begin
         if (ab_load) begin                        // Measured rate beats the bus
            baud_div <= ab_div;
            ab_arm   <= 1'b0;
         end else if (wr_en) begin
            if (wb_adr == REG_BAUD && wb_dat_i != 8'd0)
               baud_div <= {{(`UART_DIV_W-8){1'b0}}, wb_dat_i};
            if (wb_adr == REG_CTRL)
               ab_arm <= wb_dat_i[0];
         end
      end
   end

   // A zero divisor would stall both engines
   a_baud_nonzero: assert property (@(posedge clk) disable iff (!nRst)
      baud_div != '0);

   // Transmitter answers every start with busy right after
   a_tx_start_busy: assert property (@(posedge clk) disable iff (!nRst)
      tx_start |=> tx_busy);

endmodule

`default_nettype wire

// ==== hdl/uart_wb_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_wb_result (
   input  wire                    clk,
   input  wire                    nRst,
   input  wire                    wb_cyc,
   input  wire                    wb_stb,
   input  wire uart_pkg::uart_reg_e    rd_sel,
   input  wire [7:0]              rx_data,
   input  wire uart_pkg::uart_status_t status,
   input  wire uart_pkg::uart_div_t    baud_div,
   output logic [7:0]             wb_dat_o,
   output logic                   wb_ack
);
   import uart_pkg::*;

   logic       new_req;
   logic [7:0] rd_word;

   assign new_req = wb_cyc & wb_stb & !wb_ack;

   always_comb begin
      case (rd_sel)
         REG_DATA:   rd_word = rx_data;
         REG_STATUS: rd_word = status;
         REG_BAUD:   rd_word = baud_div[7:0];           // Low byte only
         default:    rd_word = {7'd0, status.ab_armed};
      endcase
   end

   always_ff @(posedge clk or negedge nRst) begin
      if (!nRst)
         wb_ack <= 1'b0;
      else
         wb_ack <= new_req;
   end

   always_ff @(posedge clk) begin
      if (new_req) wb_dat_o <= rd_word;                 // Valid in the ack cycle
   end

   // Master keeps the request up until it sees ack
   a_ack_held: assert property (@(posedge clk) disable iff (!nRst)
      wb_ack |-> wb_cyc && wb_stb);

endmodule

`default_nettype wire

// ==== testbench/uart_wb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "uart_cfg.svh"

module uart_wb_tb;
   import uart_pkg::*;

   logic                    clk;
   logic                    nRst;
   logic                    wb_cyc;
   logic                    wb_stb;
   logic                    wb_we;
   logic [`UART_ADDR_W-1:0] wb_adr;
   logic [7:0]              wb_dat_i;
   wire  [7:0]              wb_dat_o;
   wire                     wb_ack;
   logic                    rx;
   wire                     tx;

   integer seed = 3;
   int     err_cnt = 0;
   int     test_cnt = 0;
   int     test_err = 0;
   int     ack_cnt = 0;
   int     cur_div = `UART_DEFAULT_DIV;   // Rate the serial tasks use

   uart_wb uart_wb_i (
      .clk(clk), .nRst(nRst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
      .wb_adr(wb_adr), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
      .rx(rx), .tx(tx));

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Ack is stable around the falling edge
   always @(negedge clk) begin
      if (wb_ack) ack_cnt = ack_cnt + 1;
   end

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
      if (got !== exp) begin
         $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_div(input string name, input uart_div_t got, input uart_div_t exp);
      if (got !== exp) begin
         $display("error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   task automatic check_status(input string name, input uart_status_t got,
                               input uart_status_t exp);
      if (got !== exp) begin
         $display("error at %0t ns: %s got %b expected %b", $time, name, got, exp);
         err_cnt++;
      end
   endtask

   function automatic uart_status_t make_status(input logic busy, input logic valid,
                                                input logic ovr, input logic armed);
      uart_status_t s;
      s = '0;
      s.tx_busy    = busy;
      s.rx_valid   = valid;
      s.rx_overrun = ovr;
      s.ab_armed   = armed;
      return s;
   endfunction

   // One classic cycle, held until the ack edge has passed
   task automatic wb_access(input logic we, input uart_reg_e adr, input logic [7:0] wdata,
                            output logic [7:0] rdata);
      int n;
      int acks;
      acks     = ack_cnt;
      rdata    = 8'h00;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = adr;
      wb_dat_i = wdata;
      n = 0;
      do begin
         wait_cycles(1);
         n++;
      end while (!wb_ack && n < 20);
      if (!wb_ack) begin
         $display("timeout at %0t ns: no ack for %s access", $time, adr.name());
         err_cnt++;
      end
      rdata = wb_dat_o;
      wait_cycles(1);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
      wait_cycles(1);
      if (ack_cnt - acks != 1) begin
         $display("%s access at %0t ns saw %0d acks instead of one",
                  adr.name(), $time, ack_cnt - acks);
         err_cnt++;
      end
   endtask

   task automatic wb_write(input uart_reg_e adr, input logic [7:0] data);
      logic [7:0] unused;
      wb_access(1'b1, adr, data, unused);
   endtask

   task automatic wb_read(input uart_reg_e adr, output logic [7:0] data);
      wb_access(1'b0, adr, 8'h00, data);
   endtask

   // Poll STATUS until the masked flags reach the wanted state
   task automatic wait_status(input uart_status_t mask, input logic want_set);
      logic [7:0] st;
      int         n;
      n = 0;
      do begin
         wb_read(REG_STATUS, st);
         n++;
      end while ((((st & mask) != 0) != want_set) && n < 100);
      if (((st & mask) != 0) != want_set) begin
         $display("timeout at %0t ns: STATUS flags %b never became %b", $time, mask, want_set);
         err_cnt++;
      end
   endtask

   task automatic send_serial(input logic [7:0] data, input int div);
      logic [9:0] frame;
      frame = {1'b1, data, 1'b0};   // Stop, data LSB first, start
      for (int i = 0; i < 10; i++) begin
         rx = frame[i];
         wait_cycles(div);
      end
   endtask

   task automatic capture_serial(input int div, output logic [7:0] data);
      int n;
      data = 8'h00;
      n = 0;
      while (tx !== 1'b0 && n < 100) begin
         wait_cycles(1);
         n++;
      end
      if (tx !== 1'b0) begin
         $display("timeout at %0t ns: tx never started a frame", $time);
         err_cnt++;
         return;
      end
      wait_cycles(div / 2);                 // Middle of the start bit
      if (tx !== 1'b0) begin
         $display("start bit on tx ended early at %0t ns", $time);
         err_cnt++;
      end
      for (int i = 0; i < 8; i++) begin
         wait_cycles(div);
         data[i] = tx;
      end
      wait_cycles(div);
      if (tx !== 1'b1) begin
         $display("error at %0t ns: tx stop bit got %b expected 1", $time, tx);
         err_cnt++;
      end
   endtask

   task automatic end_test(input string name);
      test_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - test_err);
      test_err = err_cnt;
   endtask

   task automatic test_registers();
      logic [7:0] rd;
      wb_read(REG_BAUD, rd);
      check_div("BAUD after reset", uart_div_t'(rd), uart_div_t'(`UART_DEFAULT_DIV));
      wb_read(REG_STATUS, rd);
      check_status("STATUS after reset", rd, make_status(0, 0, 0, 0));
      wb_write(REG_BAUD, 8'd12);
      wb_read(REG_BAUD, rd);
      check_div("BAUD", uart_div_t'(rd), uart_div_t'(12));
      cur_div = 12;
      end_test("registers");
   endtask

   task automatic test_transmit();
      logic [7:0] data;
      logic [7:0] got;
      logic [7:0] rd;
      int         low_seen;
      for (int k = 0; k < 3; k++) begin
         data = $random(seed);
         fork
            wb_write(REG_DATA, data);
            capture_serial(cur_div, got);
            begin
               wait_cycles(8);            // Inside the start bit
               wb_read(REG_STATUS, rd);
               check_status("STATUS in frame", rd, make_status(1, 0, 0, 0));
               wb_write(REG_DATA, ~data); // Busy, so dropped
            end
         join
         check_byte("tx byte", got, data);
         wait_status(make_status(1, 0, 0, 0), 1'b0);
         wb_read(REG_STATUS, rd);
         check_status("STATUS after frame", rd, make_status(0, 0, 0, 0));
         low_seen = 0;
         repeat (12 * cur_div) begin
            wait_cycles(1);
            if (tx !== 1'b1) low_seen = 1;
         end
         if (low_seen != 0) begin
            $display("a second frame appeared on tx after a dropped DATA write");
            err_cnt++;
         end
      end
      end_test("transmit");
   endtask

   task automatic test_receive();
      logic [7:0] data;
      logic [7:0] rd;
      for (int k = 0; k < 3; k++) begin
         data = $random(seed);
         send_serial(data, cur_div);
         wait_status(make_status(0, 1, 0, 0), 1'b1);
         wb_read(REG_DATA, rd);
         check_byte("DATA", rd, data);
         wb_read(REG_STATUS, rd);
         check_status("STATUS after DATA read", rd, make_status(0, 0, 0, 0));
      end
      end_test("receive");
   endtask

   task automatic test_overrun();
      logic [7:0] first;
      logic [7:0] second;
      logic [7:0] rd;
      first  = $random(seed);
      second = $random(seed);
      send_serial(first, cur_div);
      send_serial(second, cur_div);
      wb_read(REG_STATUS, rd);
      check_status("STATUS on overrun", rd, make_status(0, 1, 1, 0));
      wb_read(REG_DATA, rd);
      check_byte("DATA on overrun", rd, first);
      wb_read(REG_STATUS, rd);
      check_status("STATUS after overrun read", rd, make_status(0, 0, 0, 0));
      end_test("overrun");
   endtask

   task automatic test_autobaud();
      logic [7:0] data;
      logic [7:0] rd;
      wb_write(REG_CTRL, 8'h01);
      wb_read(REG_STATUS, rd);
      check_status("STATUS armed", rd, make_status(0, 0, 0, 1));
      send_serial(8'h55, 23);
      wb_read(REG_BAUD, rd);
      check_div("BAUD measured", uart_div_t'(rd), uart_div_t'(23));
      wb_read(REG_STATUS, rd);
      check_status("STATUS after sync", rd, make_status(0, 0, 0, 0));
      cur_div = 23;
      wait_cycles(11 * cur_div);          // Receiver blanked for ten quiet bits
      data = $random(seed);
      send_serial(data, cur_div);
      wait_status(make_status(0, 1, 0, 0), 1'b1);
      wb_read(REG_DATA, rd);
      check_byte("DATA at measured rate", rd, data);
      end_test("autobaud");
   endtask

   initial begin
      nRst     = 1'b0;
      wb_cyc   = 1'b0;
      wb_stb   = 1'b0;
      wb_we    = 1'b0;
      wb_adr   = '0;
      wb_dat_i = 8'h00;
      rx       = 1'b1;                     // Idle line
      repeat (2) @(posedge clk);
      #1;
      nRst = 1'b1;
      wait_cycles(1);
      test_registers();
      test_transmit();
      test_receive();
      test_overrun();
      test_autobaud();
      $display("%0d tests run, %0d errors", test_cnt, err_cnt);
      if (err_cnt == 0)
         $display("TESTBENCH PASSED");
      else
         $display("TESTBENCH FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== uart_wb.f ====
+incdir+hdl
hdl/uart_pkg.sv
hdl/uart_wb_decode.sv
hdl/uart_baud_detect.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/uart_wb_result.sv
hdl/uart_wb.sv
testbench/uart_wb_tb.sv
